//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - design

sources:
  - design/cpuPkg.sv
  - design/cpuMemory.sv
  - design/cpuDecoder.sv
  - design/cpuExecute.sv
  - design/cpuResult.sv
  - design/cpuSequencer.sv
  - design/cpuTop.sv
  - target: test
    files:
      - verif/cpuChecker.sv
      - verif/cpuTb.sv

//--- design/cpuDecoder.sv
`timescale 1ns/1ps

module cpuDecoder (
	input  cpuPkg::byteT opcodeByte,
	output cpuPkg::ctrlT ctrl
);

	cpuPkg::opcodeT op;

	// Low nibble is ignored.
	assign op = cpuPkg::opcodeT'(opcodeByte[7:4]);

	always_comb begin
		ctrl = '0;
		case (op)
			cpuPkg::LDI: begin
				ctrl.aluOp     = cpuPkg::ALU_PASS_B;
				ctrl.accWrite  = 1'b1;
				ctrl.flagWrite = 1'b1;
			end
			cpuPkg::LDA: begin
				ctrl.aluOp          = cpuPkg::ALU_PASS_B;
				ctrl.operandFromMem = 1'b1;
				ctrl.accWrite       = 1'b1;
				ctrl.flagWrite      = 1'b1;
			end
			cpuPkg::STA: ctrl.memWrite = 1'b1;
			cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR: begin
				ctrl.operandFromMem = 1'b1;
				ctrl.accWrite       = 1'b1;
				ctrl.flagWrite      = 1'b1;
				case (op)
					cpuPkg::ADD: ctrl.aluOp = cpuPkg::ALU_ADD;
					cpuPkg::SUB: ctrl.aluOp = cpuPkg::ALU_SUB;
					cpuPkg::AND: ctrl.aluOp = cpuPkg::ALU_AND;
					cpuPkg::OR:  ctrl.aluOp = cpuPkg::ALU_OR;
					default:     ctrl.aluOp = cpuPkg::ALU_XOR;
				endcase
			end
			cpuPkg::JMP: ctrl.jump = 1'b1;
			cpuPkg::JZ:  ctrl.jumpIfZero = 1'b1;
			cpuPkg::JC:  ctrl.jumpIfCarry = 1'b1;
			cpuPkg::HLT: ctrl.halt = 1'b1;
			// NOP and codes 13 to 15.
			default: ctrl = '0;
		endcase
	end

endmodule

//--- design/cpuExecute.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuExecute (
	input  cpuPkg::ctrlT  ctrl,
	input  cpuPkg::byteT  acc,
	input  cpuPkg::flagsT flags,
	input  cpuPkg::byteT  operand,
	output cpuPkg::byteT  result,
	output cpuPkg::flagsT nextFlags,
	output logic          takeJump
);

	logic [`CPU_DATA_W:0] wide;
	logic                 arith;

	always_comb begin
		wide  = '0;
		arith = 1'b0;
		case (ctrl.aluOp)
			cpuPkg::ALU_ADD: begin
				wide  = {1'b0, acc} + {1'b0, operand};
				arith = 1'b1;
			end
			cpuPkg::ALU_SUB: begin
				// Top bit is the borrow.
				wide  = {1'b0, acc} - {1'b0, operand};
				arith = 1'b1;
			end
			cpuPkg::ALU_AND: wide = {1'b0, acc & operand};
			cpuPkg::ALU_OR:  wide = {1'b0, acc | operand};
			cpuPkg::ALU_XOR: wide = {1'b0, acc ^ operand};
			default:         wide = {1'b0, operand};
		endcase
	end

	assign result = wide[`CPU_DATA_W-1:0];

	// Logic ops and loads clear carry.
	always_comb begin
		nextFlags       = flags;
		nextFlags.zero  = (result == '0);
		nextFlags.carry = arith & wide[`CPU_DATA_W];
	end

	// Branches test the flags left by earlier instructions.
	assign takeJump = ctrl.jump
		| (ctrl.jumpIfZero & flags.zero)
		| (ctrl.jumpIfCarry & flags.carry);

endmodule

//--- design/cpuMemory.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuMemory (
	input  logic         clk,
	input  logic         nRst,
	input  cpuPkg::addrT address,
	input  cpuPkg::byteT in,
	input  logic         we,
	output cpuPkg::byteT out
);

	cpuPkg::byteT mem [`CPU_MEM_DEPTH];

	// Asynchronous read.
	assign out = mem[address];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[address] <= in;
		end
	end

endmodule

//--- design/cpuPkg.sv
`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [`CPU_DATA_W-1:0] byteT;
	typedef logic [`CPU_ADDR_W-1:0] addrT;

	typedef enum logic [3:0] {
		NOP = `OP_NOP,
		LDI = `OP_LDI,
		LDA = `OP_LDA,
		STA = `OP_STA,
		ADD = `OP_ADD,
		SUB = `OP_SUB,
		AND = `OP_AND,
		OR  = `OP_OR,
		XOR = `OP_XOR,
		JMP = `OP_JMP,
		JZ  = `OP_JZ,
		JC  = `OP_JC,
		HLT = `OP_HLT
	} opcodeT;

	// Pass-B must stay at zero so an all-zero control word is a NOP.
	typedef enum logic [2:0] {
		ALU_PASS_B = 3'd0,
		ALU_ADD    = 3'd1,
		ALU_SUB    = 3'd2,
		ALU_AND    = 3'd3,
		ALU_OR     = 3'd4,
		ALU_XOR    = 3'd5
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic  operandFromMem;
		logic  accWrite;
		logic  flagWrite;
		logic  memWrite;
		logic  jump;
		logic  jumpIfZero;
		logic  jumpIfCarry;
		logic  halt;
	} ctrlT;

	typedef struct packed {
		logic zero;
		logic carry;
	} flagsT;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_OP,
		FETCH_ARG,
		EXEC,
		HALT
	} seqStateT;

endpackage

//--- design/cpuResult.sv
`timescale 1ns/1ps

module cpuResult (
	input  logic          clk,
	input  logic          nRst,
	input  logic          accWrite,
	input  logic          flagWrite,
	input  cpuPkg::byteT  result,
	input  cpuPkg::flagsT nextFlags,
	output cpuPkg::byteT  acc,
	output cpuPkg::flagsT flags
);

	// Accumulator.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc <= '0;
		end else if (accWrite) begin
			acc <= result;
		end
	end

	// Zero and carry.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			flags <= '0;
		end else if (flagWrite) begin
			flags <= nextFlags;
		end
	end

endmodule

//--- design/cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer (
	input  logic          clk,
	input  logic          nRst,
	input  logic          run,
	input  cpuPkg::addrT  hostAddr,
	input  cpuPkg::byteT  hostData,
	input  logic          hostWe,
	input  cpuPkg::byteT  memOut,
	output cpuPkg::addrT  memAddr,
	output cpuPkg::byteT  memIn,
	output logic          memWe,
	output cpuPkg::byteT  acc,
	output cpuPkg::flagsT flags,
	output cpuPkg::addrT  pc,
	output logic          halted
);

	cpuPkg::seqStateT state;
	cpuPkg::seqStateT nextState;
	cpuPkg::byteT     opReg;
	cpuPkg::byteT     argReg;
	cpuPkg::ctrlT     ctrl;
	cpuPkg::byteT     operand;
	cpuPkg::byteT     result;
	cpuPkg::flagsT    nextFlags;
	logic             takeJump;
	logic             inExec;
	logic             hostOwned;

	assign inExec    = (state == cpuPkg::EXEC);
	assign hostOwned = (state == cpuPkg::IDLE) || (state == cpuPkg::HALT);
	assign halted    = (state == cpuPkg::HALT);

	always_comb begin
		nextState = state;
		if (!run) begin
			nextState = cpuPkg::IDLE;
		end else begin
			case (state)
				cpuPkg::IDLE:      nextState = cpuPkg::FETCH_OP;
				cpuPkg::FETCH_OP:  nextState = cpuPkg::FETCH_ARG;
				cpuPkg::FETCH_ARG: nextState = cpuPkg::EXEC;
				cpuPkg::EXEC:      nextState = ctrl.halt ? cpuPkg::HALT : cpuPkg::FETCH_OP;
				default:           nextState = cpuPkg::HALT;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= cpuPkg::IDLE;
		end else begin
			state <= nextState;
		end
	end

	// Program counter, wraps at 256.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else begin
			case (state)
				cpuPkg::IDLE: pc <= '0;
				cpuPkg::FETCH_OP, cpuPkg::FETCH_ARG: pc <= pc + cpuPkg::addrT'(1);
				cpuPkg::EXEC: begin
					if (takeJump) begin
						pc <= argReg;
					end
				end
				default: pc <= pc;
			endcase
		end
	end

	// Instruction bytes.
	always_ff @(posedge clk) begin
		if (state == cpuPkg::FETCH_OP) begin
			opReg <= memOut;
		end
		if (state == cpuPkg::FETCH_ARG) begin
			argReg <= memOut;
		end
	end

	always_comb begin
		case (state)
			cpuPkg::FETCH_OP, cpuPkg::FETCH_ARG: memAddr = pc;
			cpuPkg::EXEC:                        memAddr = argReg;
			default:                             memAddr = hostAddr;
		endcase
	end

	assign memIn = hostOwned ? hostData : acc;
	assign memWe = hostOwned ? hostWe : (inExec & ctrl.memWrite);

	// Memory holds mem[arg] during EXEC.
	assign operand = ctrl.operandFromMem ? memOut : argReg;

	cpuDecoder cpuDecoder_inst (
		.opcodeByte(opReg),
		.ctrl      (ctrl)
	);

	cpuExecute cpuExecute_inst (
		.ctrl     (ctrl),
		.acc      (acc),
		.flags    (flags),
		.operand  (operand),
		.result   (result),
		.nextFlags(nextFlags),
		.takeJump (takeJump)
	);

	cpuResult cpuResult_inst (
		.clk      (clk),
		.nRst     (nRst),
		.accWrite (inExec & ctrl.accWrite),
		.flagWrite(inExec & ctrl.flagWrite),
		.result   (result),
		.nextFlags(nextFlags),
		.acc      (acc),
		.flags    (flags)
	);

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic          clk,
	input  logic          nRst,
	input  logic          run,
	input  cpuPkg::addrT  hostAddr,
	input  cpuPkg::byteT  hostData,
	input  logic          hostWe,
	output cpuPkg::byteT  memData,
	output cpuPkg::byteT  acc,
	output cpuPkg::flagsT flags,
	output cpuPkg::addrT  pc,
	output logic          halted
);

	cpuPkg::addrT memAddr;
	cpuPkg::byteT memIn;
	logic         memWe;

	cpuSequencer cpuSequencer_inst (
		.clk     (clk),
		.nRst    (nRst),
		.run     (run),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostWe  (hostWe),
		.memOut  (memData),
		.memAddr (memAddr),
		.memIn   (memIn),
		.memWe   (memWe),
		.acc     (acc),
		.flags   (flags),
		.pc      (pc),
		.halted  (halted)
	);

	// Read data doubles as the host readback port.
	cpuMemory cpuMemory_inst (
		.clk    (clk),
		.nRst   (nRst),
		.address(memAddr),
		.in     (memIn),
		.we     (memWe),
		.out    (memData)
	);

endmodule

//--- design/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_DATA_W    8
`define CPU_ADDR_W    8
`define CPU_MEM_DEPTH 256

// Opcodes live in the upper nibble of the first instruction byte.
`define OP_NOP 4'd0
`define OP_LDI 4'd1
`define OP_LDA 4'd2
`define OP_STA 4'd3
`define OP_ADD 4'd4
`define OP_SUB 4'd5
`define OP_AND 4'd6
`define OP_OR  4'd7
`define OP_XOR 4'd8
`define OP_JMP 4'd9
`define OP_JZ  4'd10
`define OP_JC  4'd11
`define OP_HLT 4'd12

`endif

//--- sources.f
+incdir+design
design/cpuPkg.sv
design/cpuMemory.sv
design/cpuDecoder.sv
design/cpuExecute.sv
design/cpuResult.sv
design/cpuSequencer.sv
design/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv

//--- verif/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker (
	input  logic          clk,
	input  logic          nRst,
	input  logic          halted,
	input  cpuPkg::byteT  acc,
	input  cpuPkg::flagsT flags,
	input  cpuPkg::addrT  pc,
	input  cpuPkg::byteT  memData,
	input  logic [127:0]  testName,
	input  cpuPkg::byteT  expAcc,
	input  cpuPkg::flagsT expFlags,
	input  cpuPkg::byteT  expByte,
	input  logic          compare,
	output int            errors
);

	logic haltedQ;

	initial begin
		errors = 0;
	end

	task automatic checkValue(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %0s %0s expected %h actual %h", testName, what, expected, actual);
			errors++;
		end
	endtask

	// Outputs still hold their reset values here.
	always @(posedge nRst) begin
		checkValue("acc after reset", 8'h00, acc);
		checkValue("zero after reset", 8'h00, {7'b0, flags.zero});
		checkValue("carry after reset", 8'h00, {7'b0, flags.carry});
		checkValue("halted after reset", 8'h00, {7'b0, halted});
		checkValue("pc after reset", 8'h00, pc);
	end

	// Results are final once the core sits in HALT.
	always @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			haltedQ <= 1'b0;
		end else begin
			haltedQ <= halted;
			if (halted && !haltedQ) begin
				checkValue("acc", expAcc, acc);
				checkValue("zero", {7'b0, expFlags.zero}, {7'b0, flags.zero});
				checkValue("carry", {7'b0, expFlags.carry}, {7'b0, flags.carry});
			end
			if (compare) begin
				checkValue("memory", expByte, memData);
			end
		end
	end

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb;

	typedef struct packed {
		logic [127:0]  name;
		int            start;
		int            len;
		cpuPkg::byteT  acc;
		cpuPkg::flagsT flags;
		cpuPkg::addrT  chkAddr;
		cpuPkg::byteT  chkByte;
	} testT;

	logic          clk;
	logic          nRst;
	logic          run;
	cpuPkg::addrT  hostAddr;
	cpuPkg::byteT  hostData;
	logic          hostWe;
	cpuPkg::byteT  memData;
	cpuPkg::byteT  acc;
	cpuPkg::flagsT flags;
	cpuPkg::addrT  pc;
	logic          halted;

	logic [127:0]  testName;
	cpuPkg::byteT  expAcc;
	cpuPkg::flagsT expFlags;
	cpuPkg::byteT  expByte;
	logic          compare;
	int            mismatches;
	int            otherErrors;
	int            cycles;
	int            limit;
	testT          tests[$];
	cpuPkg::byteT  progBytes[$];

	cpuTop cpuTop_inst (
		.clk     (clk),
		.nRst    (nRst),
		.run     (run),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostWe  (hostWe),
		.memData (memData),
		.acc     (acc),
		.flags   (flags),
		.pc      (pc),
		.halted  (halted)
	);

	cpuChecker cpuChecker_inst (
		.clk     (clk),
		.nRst    (nRst),
		.halted  (halted),
		.acc     (acc),
		.flags   (flags),
		.pc      (pc),
		.memData (memData),
		.testName(testName),
		.expAcc  (expAcc),
		.expFlags(expFlags),
		.expByte (expByte),
		.compare (compare),
		.errors  (mismatches)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic finishRun();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	// Header line per test, then one line of program bytes.
	task automatic readTests();
		int           fd;
		int           c;
		int           b;
		string        line;
		logic [127:0] name;
		int           len;
		int           a;
		int           cy;
		int           z;
		int           ca;
		int           cb;
		testT         t;
		fd = $fopen("verif/cpu_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open verif/cpu_tests.txt");
			otherErrors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			c = $sscanf(line, "%s %d %h %h %h %h %h", name, len, a, cy, z, ca, cb);
			if (c != 7) begin
				$display("ERROR: malformed test header in verif/cpu_tests.txt");
				otherErrors++;
				break;
			end
			t.name = name;
			t.start = progBytes.size();
			t.len = len;
			t.acc = a[7:0];
			t.flags.carry = cy[0];
			t.flags.zero = z[0];
			t.chkAddr = ca[7:0];
			t.chkByte = cb[7:0];
			for (int i = 0; i < len; i++) begin
				c = $fscanf(fd, "%h", b);
				if (c != 1) begin
					$display("ERROR: program bytes missing in verif/cpu_tests.txt");
					otherErrors++;
					break;
				end
				progBytes.push_back(b[7:0]);
			end
			tests.push_back(t);
		end
		$fclose(fd);
	endtask

	// Every location must read back as zero.
	task automatic checkReset();
		testName = "reset";
		expByte = '0;
		for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
			hostAddr = cpuPkg::addrT'(i);
			compare = 1'b1;
			@(negedge clk);
		end
		compare = 1'b0;
	endtask

	task automatic runTest(input testT t);
		testName = t.name;
		expAcc = t.acc;
		expFlags = t.flags;
		expByte = t.chkByte;
		for (int i = 0; i < t.len; i++) begin
			hostAddr = cpuPkg::addrT'(i);
			hostData = progBytes[t.start + i];
			hostWe = 1'b1;
			@(negedge clk);
		end
		hostWe = 1'b0;
		run = 1'b1;
		@(negedge clk);
		while (!halted) begin
			@(negedge clk);
		end
		run = 1'b0;
		hostAddr = t.chkAddr;
		compare = 1'b1;
		@(negedge clk);
		compare = 1'b0;
	endtask

	initial begin
		nRst = 1'b0;
		run = 1'b0;
		hostAddr = '0;
		hostData = '0;
		hostWe = 1'b0;
		compare = 1'b0;
		testName = "reset";
		expAcc = '0;
		expFlags = '0;
		expByte = '0;
		otherErrors = 0;
		limit = 0;
		readTests();
		limit = 10 + 2 * `CPU_MEM_DEPTH;
		foreach (tests[i]) begin
			limit += tests[i].len + 3 * `CPU_MEM_DEPTH;
		end
		repeat (10) @(negedge clk);
		nRst = 1'b1;
		checkReset();
		foreach (tests[i]) begin
			runTest(tests[i]);
		end
		@(negedge clk);
		finishRun();
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("TIMEOUT: core never halted within %0d cycles", limit);
		otherErrors++;
		finishRun();
	end

endmodule

//--- verif/cpu_tests.txt
# name len acc carry zero checkAddr checkByte (len decimal, rest hex)
# next line: program bytes in hex, loaded from address 0
ldi_zero 4 00 0 1 00 10
10 00 C0 00

ldi_value 4 A5 0 0 02 C0
10 A5 C0 00

add_carry 9 10 1 0 08 20
10 F0 40 08 C0 00 00 00 20

sub_borrow 9 FF 1 0 08 06
10 05 50 08 C0 00 00 00 06

sub_zero 7 00 0 1 06 33
10 33 50 06 C0 00 33

logic_ops 16 00 0 1 0F 1C
10 F0 40 0C 70 0D 60 0E 80 0F C0 00 20 0F 3C 1C

sta_store 6 5A 0 0 20 5A
10 5A 30 20 C0 00

branches 27 00 1 1 1A 01
10 01 A0 08 10 00 A0 0A C0 00 10 FF 40 1A B0 14 10 77 C0 00 90 18 10 66 C0 00 01

countdown 15 00 0 1 40 01
10 03 30 40 50 0E A0 0A 90 02 30 41 C0 00 01

nop_codes 15 01 1 0 0E 02
10 FF 40 0E D0 55 E7 AA FF 00 00 00 C0 00 02
